// File: compile.f
+incdir+include
design/rv_isa_pkg.sv
design/fetch_pkg.sv
design/early_decoder.sv
design/pc_controller.sv
design/fetch_stage.sv
tests/fetch_stage_properties.sv
tests/fetch_stage_tb.sv

// File: Bender.yml
package:
  name: fetch_stage

export_include_dirs:
  - include

sources:
  - files:
      - design/rv_isa_pkg.sv
      - design/fetch_pkg.sv
      - design/early_decoder.sv
      - design/pc_controller.sv
      - design/fetch_stage.sv
  - target: test
    files:
      - tests/fetch_stage_properties.sv
      - tests/fetch_stage_tb.sv

// File: tests/fetch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage_tb
    import rv_isa_pkg::*;
    import fetch_pkg::*;
();

    localparam int MIN_CYCLES = 2000;
    localparam int MAX_CYCLES = 50000;
    localparam int GOAL       = 8;

    logic             clk;
    logic             reset;
    logic             bubble_i;
    logic             misprediction_i;
    logic             flush_i;
    logic [`XLEN-1:0] instruction_i;
    logic             instruction_valid_i;
    logic [`XLEN-1:0] correct_pc_i;
    logic [`XLEN-1:0] current_pc_o;
    logic [`XLEN-1:0] instruction_o;
    logic [`XLEN-1:0] imm_o;
    logic [`XLEN-1:0] pc_plus_o;
    logic             branch_prediction_o;

    logic [31:0] program_mem [0:255];
    logic [31:0] rng;
    logic        checking;
    // JAL, JALR, backward branch, forward branch, flush, redirect under bubble
    int          hits [0:5];

    // Model state after the latest edge, and after the coming one
    logic [31:0] exp_pc, exp_insn, exp_imm, exp_plus;
    logic        exp_parked, exp_pred;
    logic [31:0] pend_pc, pend_insn, pend_imm, pend_plus;
    logic        pend_parked, pend_pred;

    fetch_stage u_fetch_stage (
        .clk                 (clk),
        .reset               (reset),
        .bubble_i            (bubble_i),
        .misprediction_i     (misprediction_i),
        .flush_i             (flush_i),
        .instruction_i       (instruction_i),
        .instruction_valid_i (instruction_valid_i),
        .correct_pc_i        (correct_pc_i),
        .current_pc_o        (current_pc_o),
        .instruction_o       (instruction_o),
        .imm_o               (imm_o),
        .pc_plus_o           (pc_plus_o),
        .branch_prediction_o (branch_prediction_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // One random word of the program image
    // Offsets stay word aligned
    function automatic logic [31:0] random_insn();
        logic [31:0] r;
        logic [20:0] mag;
        logic [20:0] neg;
        logic [20:0] off;
        r   = next_rand();
        mag = ({17'd0, r[11:8]} + 21'd1) << 2;
        neg = -mag;
        off = r[12] ? neg : mag;
        case (r[2:0])
            3'd0, 3'd1: return {r[31:20], r[19:15], 3'b000, r[17:13], OPC_OP_IMM};
            3'd2:       return {r[31:12], r[17:13], 7'b011_0111};
            3'd3:       return {off[20], off[10:1], off[11], off[19:12], r[17:13], OPC_JAL};
            3'd4:       return {mag[12], mag[10:5], r[24:20], r[19:15], 3'b000,
                                mag[4:1], mag[11], OPC_BRANCH};
            3'd5:       return {neg[12], neg[10:5], r[24:20], r[19:15], 3'b001,
                                neg[4:1], neg[11], OPC_BRANCH};
            3'd6:       return {r[31:20], r[19:15], 3'b000, r[17:13], OPC_JALR};
            default:    return {r[31:20], r[19:15], 3'b010, r[17:13], OPC_LOAD};
        endcase
    endfunction

    // Expected PC, park flag and IF/ID contents after one edge
    function automatic void reference_step(
        input  logic [31:0] pc, word, cpc, out_insn, out_imm, out_plus,
        input  logic        valid, bubble, flush, mispred, parked, out_pred,
        output logic [31:0] nxt_pc, nxt_insn, nxt_imm, nxt_plus,
        output logic        nxt_parked, nxt_pred
    );
        logic [31:0] imm;
        logic        redirect;
        case (word[6:0])
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: imm = {{20{word[31]}}, word[31:20]};
            OPC_BRANCH: imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            OPC_JAL:    imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            default:    imm = 32'd0;
        endcase
        redirect   = (word[6:0] == OPC_JAL) || (word[6:0] == OPC_BRANCH && imm[31]);
        nxt_pc     = pc;
        nxt_parked = parked;
        if (mispred) begin
            nxt_pc     = cpc;
            nxt_parked = 1'b0;
        end else if (!bubble && valid && !parked) begin
            if (redirect)
                nxt_pc = pc + imm;
            else if (word[6:0] == OPC_JALR)
                nxt_parked = 1'b1;
            else
                nxt_pc = pc + `PC_STEP;
        end
        if (bubble) begin
            {nxt_insn, nxt_imm, nxt_plus, nxt_pred} = {out_insn, out_imm, out_plus, out_pred};
        end else if (flush || !valid || parked) begin
            {nxt_insn, nxt_imm, nxt_plus, nxt_pred} = {`NOP_INSN, 32'd0, 32'd0, 1'b0};
        end else begin
            {nxt_insn, nxt_imm, nxt_plus, nxt_pred} = {word, imm, pc + `PC_STEP, redirect};
        end
    endfunction

    function automatic logic goals_met();
        foreach (hits[k])
            if (hits[k] < GOAL) return 1'b0;
        return 1'b1;
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want)
            report_failure($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, want));
    endtask

    always @(negedge clk) begin
        if (checking) begin
            if (u_fetch_stage.u_fetch_stage_properties.fail_count != 0)
                report_failure("a bound assertion on the fetch stage failed");
            compare_value("current_pc_o", current_pc_o, exp_pc);
            compare_value("instruction_o", instruction_o, exp_insn);
            compare_value("imm_o", imm_o, exp_imm);
            compare_value("pc_plus_o", pc_plus_o, exp_plus);
            compare_value("branch_prediction_o", {31'd0, branch_prediction_o}, {31'd0, exp_pred});
        end
    end

    initial begin
        logic [31:0] r;
        int          cycles;
        rng                 = 32'he55de8b7;
        reset               = 1'b0;
        bubble_i            = 1'b0;
        misprediction_i     = 1'b0;
        flush_i             = 1'b0;
        instruction_i       = `NOP_INSN;
        instruction_valid_i = 1'b0;
        correct_pc_i        = '0;
        checking            = 1'b0;
        cycles              = 0;
        foreach (hits[k])
            hits[k] = 0;
        for (int a = 0; a < 256; a++)
            program_mem[a] = random_insn();
        // State right after reset
        {pend_pc, pend_insn, pend_imm, pend_plus} = {`RESET_PC, 96'd0};
        {pend_parked, pend_pred} = 2'b00;

        repeat (10) @(posedge clk);
        #1;
        reset    = 1'b1;
        checking = 1'b1;
        while (cycles < MIN_CYCLES || !goals_met()) begin
            if (cycles >= MAX_CYCLES)
                report_failure("not every fetch scenario was reached before the cycle limit");
            {exp_pc, exp_insn, exp_imm, exp_plus} = {pend_pc, pend_insn, pend_imm, pend_plus};
            {exp_parked, exp_pred} = {pend_parked, pend_pred};
            r = next_rand();
            bubble_i            = (r[2:0] == 3'd0);
            flush_i             = (r[6:3] == 4'd0);
            instruction_valid_i = (r[9:7] != 3'd0);
            // Redirects come more often while fetch waits on a JALR
            misprediction_i     = exp_parked ? (r[11:10] == 2'd0) : (r[15:12] == 4'd0);
            correct_pc_i        = {22'd0, r[23:16], 2'b00};
            instruction_i       = program_mem[current_pc_o[9:2]];
            reference_step(exp_pc, instruction_i, correct_pc_i, exp_insn, exp_imm, exp_plus,
                           instruction_valid_i, bubble_i, flush_i, misprediction_i,
                           exp_parked, exp_pred, pend_pc, pend_insn, pend_imm, pend_plus,
                           pend_parked, pend_pred);
            if (misprediction_i && bubble_i)
                hits[5]++;
            if (flush_i && !bubble_i)
                hits[4]++;
            if (!misprediction_i && !bubble_i && instruction_valid_i && !exp_parked) begin
                case (instruction_i[6:0])
                    OPC_JAL:    hits[0]++;
                    OPC_JALR:   hits[1]++;
                    OPC_BRANCH: hits[instruction_i[31] ? 2 : 3]++;
                    default:    ;
                endcase
            end
            cycles++;
            @(posedge clk);
            #1;
        end
        {exp_pc, exp_insn, exp_imm, exp_plus} = {pend_pc, pend_insn, pend_imm, pend_plus};
        exp_pred = pend_pred;
        @(posedge clk);
        #1;

        if (u_fetch_stage.u_fetch_stage_properties.fail_count != 0) begin
            report_failure("the bound property checker saw assertion failures");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tests/fetch_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage_properties (
    input logic             clk,
    input logic             reset,
    input logic             bubble_i,
    input logic             flush_i,
    input logic [`XLEN-1:0] current_pc_o,
    input logic [`XLEN-1:0] instruction_o,
    input logic [`XLEN-1:0] imm_o,
    input logic [`XLEN-1:0] pc_plus_o,
    input logic             branch_prediction_o
);

    int unsigned fail_count = 0;

    // Back-pressure freezes the IF/ID register
    hold_on_bubble: assert property (@(posedge clk) disable iff (!reset)
        bubble_i |=> $stable(instruction_o) && $stable(imm_o)
                     && $stable(pc_plus_o) && $stable(branch_prediction_o))
        else begin
            $error("IF/ID outputs changed under a bubble");
            fail_count++;
        end

    // Flush without bubble leaves a clean NOP for decode
    nop_on_flush: assert property (@(posedge clk) disable iff (!reset)
        !bubble_i && flush_i |=> instruction_o == `NOP_INSN && imm_o == '0
                                 && pc_plus_o == '0 && !branch_prediction_o)
        else begin
            $error("flush did not produce a NOP");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!reset)
        current_pc_o[1:0] == 2'b00)
        else begin
            $error("fetch address is not word aligned");
            fail_count++;
        end

endmodule

bind fetch_stage fetch_stage_properties u_fetch_stage_properties (
    .clk                 (clk),
    .reset               (reset),
    .bubble_i            (bubble_i),
    .flush_i             (flush_i),
    .current_pc_o        (current_pc_o),
    .instruction_o       (instruction_o),
    .imm_o               (imm_o),
    .pc_plus_o           (pc_plus_o),
    .branch_prediction_o (branch_prediction_o)
);

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage (
    input  logic             clk,
    input  logic             reset,
    input  logic             bubble_i,
    input  logic             misprediction_i,
    input  logic             flush_i,
    input  logic [`XLEN-1:0] instruction_i,
    input  logic             instruction_valid_i,
    input  logic [`XLEN-1:0] correct_pc_i,
    output logic [`XLEN-1:0] current_pc_o,

    // IF/ID register outputs
    output logic [`XLEN-1:0] instruction_o,
    output logic [`XLEN-1:0] imm_o,
    output logic [`XLEN-1:0] pc_plus_o,
    output logic             branch_prediction_o
);

    logic [`XLEN-1:0] imm;
    logic             jump;
    logic             jalr;
    logic [`XLEN-1:0] pc_save;
    logic             parked;
    logic             issue;

    early_decoder u_early_decoder (
        .instruction_i (instruction_i),
        .imm_o         (imm),
        .jump_o        (jump),
        .jalr_o        (jalr)
    );

    pc_controller u_pc_controller (
        .clk                 (clk),
        .reset               (reset),
        .bubble_i            (bubble_i),
        .instruction_valid_i (instruction_valid_i),
        .jump_i              (jump),
        .jalr_i              (jalr),
        .imm_i               (imm),
        .misprediction_i     (misprediction_i),
        .correct_pc_i        (correct_pc_i),
        .current_pc_o        (current_pc_o),
        .pc_save_o           (pc_save),
        .parked_o            (parked)
    );

    // Only a fresh word fetched while not parked goes to decode
    assign issue = instruction_valid_i && !parked;

    // IF/ID register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            instruction_o       <= '0;
            imm_o               <= '0;
            pc_plus_o           <= '0;
            branch_prediction_o <= 1'b0;
        end else if (!bubble_i) begin
            if (flush_i || !issue) begin
                // Canonical NOP with cleared side fields
                instruction_o       <= `NOP_INSN;
                imm_o               <= '0;
                pc_plus_o           <= '0;
                branch_prediction_o <= 1'b0;
            end else begin
                instruction_o       <= instruction_i;
                imm_o               <= imm;
                pc_plus_o           <= pc_save;
                // JAL counts as predicted taken too
                branch_prediction_o <= jump;
            end
        end
        // Bubble: hold everything
    end

endmodule

`default_nettype wire

// File: design/pc_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module pc_controller
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             bubble_i,
    input  logic             instruction_valid_i,
    input  logic             jump_i,
    input  logic             jalr_i,
    input  logic [`XLEN-1:0] imm_i,
    input  logic             misprediction_i,
    input  logic [`XLEN-1:0] correct_pc_i,
    output logic [`XLEN-1:0] current_pc_o,
    output logic [`XLEN-1:0] pc_save_o,
    output logic             parked_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;
    logic             parked_q;
    logic             parked_next;

    // Next PC, highest priority first
    always_comb begin
        pc_next     = pc_q;
        parked_next = parked_q;
        if (misprediction_i) begin
            // Back end redirect wins even under a bubble
            pc_next     = correct_pc_i;
            parked_next = 1'b0;
        end else if (!bubble_i && instruction_valid_i && !parked_q) begin
            if (jump_i) begin
                pc_next = pc_q + imm_i;
            end else if (jalr_i) begin
                // Wait here for the redirect
                parked_next = 1'b1;
            end else begin
                pc_next = link_addr(pc_q);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q     <= `RESET_PC;
            parked_q <= 1'b0;
        end else begin
            pc_q     <= pc_next;
            parked_q <= parked_next;
        end
    end

    assign current_pc_o = pc_q;
    assign pc_save_o    = link_addr(pc_q);
    assign parked_o     = parked_q;

endmodule

`default_nettype wire

// File: design/early_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module early_decoder
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  logic [`XLEN-1:0] instruction_i,
    output logic [`XLEN-1:0] imm_o,
    output logic             jump_o,
    output logic             jalr_o
);

    rv_insn_u         insn;
    logic [6:0]       opcode;
    logic [`XLEN-1:0] imm_i_type;
    logic [`XLEN-1:0] imm_b_type;
    logic [`XLEN-1:0] imm_j_type;
    logic             is_jal;
    logic             is_branch;

    assign insn   = instruction_i;
    // Opcode sits in the same bits for every format
    assign opcode = insn.i.opcode;

    // Sign-extended immediates, one per format
    assign imm_i_type = {{(`XLEN-12){insn.i.imm[11]}}, insn.i.imm};

    assign imm_b_type = {{(`XLEN-13){insn.b.imm12}},
                         insn.b.imm12,
                         insn.b.imm11,
                         insn.b.imm10_5,
                         insn.b.imm4_1,
                         1'b0};

    assign imm_j_type = {{(`XLEN-21){insn.j.imm20}},
                         insn.j.imm20,
                         insn.j.imm19_12,
                         insn.j.imm11,
                         insn.j.imm10_1,
                         1'b0};

    always_comb begin
        case (opcode)
            OPC_JALR,
            OPC_OP_IMM,
            OPC_LOAD:   imm_o = imm_i_type;
            OPC_BRANCH: imm_o = imm_b_type;
            OPC_JAL:    imm_o = imm_j_type;
            default:    imm_o = '0;
        endcase
    end

    assign is_jal    = (opcode == OPC_JAL);
    assign is_branch = (opcode == OPC_BRANCH);

    // Redirect in fetch on JAL or a backward branch
    assign jump_o = is_jal || (is_branch && predict_taken(imm_b_type));

    // Target depends on rs1, resolved later in the pipe
    assign jalr_o = (opcode == OPC_JALR);

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // Static direction rule for conditional branches
    // Backward offset means a loop, so predict taken
    function automatic logic predict_taken(input logic [`XLEN-1:0] imm);
        return imm[`XLEN-1];
    endfunction

    // Return address for JAL/JALR and fall-through of a branch
    function automatic logic [`XLEN-1:0] link_addr(input logic [`XLEN-1:0] pc);
        return pc + `PC_STEP;
    endfunction

endpackage

`default_nettype wire

// File: design/rv_isa_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package rv_isa_pkg;

    // Major opcodes seen by the early decoder
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    // I-format ALU and load words, which carry an I immediate
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;

    // One instruction word seen through each encoding format
    typedef union packed {
        logic [`XLEN-1:0] word;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // Branch offset bits are scattered around rs1/rs2
        struct packed {
            logic        imm12;
            logic [5:0]  imm10_5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4_1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
        // Jump offset, bit 0 implied zero
        struct packed {
            logic        imm20;
            logic [9:0]  imm10_1;
            logic        imm11;
            logic [7:0]  imm19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } rv_insn_u;

endpackage

`default_nettype wire

// File: include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Data and address width, one RV32 word
`define XLEN 32

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

// Sequential fetch increment
`define PC_STEP 32'd4

// ADDI x0, x0, 0
`define NOP_INSN 32'h0000_0013

`endif
